// ==== dv/motorPwmTb.sv ====
`timescale 1ns/100ps

module motorPwmTb
    import motorPwmPkg::*;
();

    localparam int NUM_RUNS = 3;
    localparam int RESET_CYCLES = 2;
    // step windows inside one run
    localparam int SHORT_END = 6;
    localparam int IDLE_END = 10;
    localparam int SAT_END = 14;
    localparam int BURST_END = 24;
    localparam int RUN_STEPS = 34;
    // longest step the cfg picker can give
    localparam int MAX_STEP = 72;
    localparam int TIMEOUT_CYCLES = NUM_RUNS * (RUN_STEPS * MAX_STEP + RESET_CYCLES + 4) + 100;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic     clk;
    logic     arstN;
    motorCfgT cfg = '0;
    logic     cmdValid = 1'b0;
    stepCmdT  cmd = '0;
    logic     pwm;
    logic     stepLast;
    logic     creditReturn;

    logic [31:0] lfsr = 32'd42;
    int timeoutCnt = 0;
    int pwmErrs = 0;
    int stepErrs = 0;
    int creditErrs = 0;
    int otherErrs = 0;

    // reference model state
    stepCmdT cmdQ[$];
    int   cycleIdx = 0;
    int   stepIdx = 0;
    int   hostCredits = FIFO_DEPTH;
    int   remModel = 0;
    int   onModel = 0;
    int   phase = 0;
    logic expPwm = 1'b0;
    logic sentThisStep = 1'b0;
    logic retSeen = 1'b0;

    motorPwmTop u_motorPwmTop (
        .clk          (clk),
        .arstN        (arstN),
        .cfg          (cfg),
        .cmdValid     (cmdValid),
        .cmd          (cmd),
        .pwm          (pwm),
        .stepLast     (stepLast),
        .creditReturn (creditReturn)
    );

    bind motorPwmTop motorPwm_sva u_motorPwmSva (
        .clk          (clk),
        .arstN        (arstN),
        .cfg          (cfg),
        .stepLast     (stepLast),
        .notEmpty     (notEmpty),
        .creditReturn (creditReturn),
        .pwm          (pwm),
        .onTime       (u_pwmGenerator.onTime)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // galois lfsr, one step per bit taken
    function automatic int nextBits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return v;
    endfunction

    // 0 short, 2 past a full period, else anything up to the period
    function automatic logic [PULSE_W-1:0] pickPulse(input int sel);
        int len;
        case (sel)
            0: len = nextBits(4) % int'(cfg.minPulse);
            2: len = int'(cfg.pwmPeriod) + 1 + nextBits(3);
            default: len = nextBits(5) % (int'(cfg.pwmPeriod) + 1);
        endcase
        return PULSE_W'(len);
    endfunction

    task automatic checkPwm(input logic got, input logic exp);
        if (got !== exp) begin
            pwmErrs++;
            $display("[FAIL] pwm got %h expected %h at cycle %0d", got, exp, cycleIdx);
        end
    endtask

    task automatic compareStepLast(input logic got, input logic exp);
        if (got !== exp) begin
            stepErrs++;
            $display("[FAIL] stepLast got %h expected %h at cycle %0d", got, exp, cycleIdx);
        end
    endtask

    task automatic expectCredits(input logic [FIFO_CNT_W-1:0] got,
                                 input logic [FIFO_CNT_W-1:0] exp);
        if (got !== exp) begin
            creditErrs++;
            $display("[FAIL] credits got %h expected %h at cycle %0d", got, exp, cycleIdx);
        end
    endtask

    // model step and host stimulus, both at the rising edge
    always @(posedge clk) begin
        stepCmdT headCmd;
        int   sum;
        int   per;
        int   sel;
        logic sendNow;
        per = int'(cfg.pwmPeriod);
        sel = 0;
        sendNow = 1'b0;
        if (!arstN) begin
            // fresh cfg while the DUT is held
            per = 4 + nextBits(4);
            cfg.pwmPeriod <= PWM_W'(per);
            cfg.minPulse <= PWM_W'(2 + nextBits(4) % (per - 2));
            cfg.stepPeriod <= STEP_W'(2 * per + 3 + nextBits(5));
            cmdQ.delete();
            cycleIdx = 0;
            stepIdx = 0;
            hostCredits = FIFO_DEPTH;
            remModel = 0;
            onModel = 0;
            phase = 0;
            expPwm = 1'b0;
            sentThisStep = 1'b0;
            cmdValid <= 1'b0;
        end else begin
            hostCredits += int'(retSeen);
            if (cycleIdx > 0 && cycleIdx % int'(cfg.stepPeriod) == 0) begin
                // boundary takes the head entry, or zero when idle
                sum = remModel;
                if (cmdQ.size() > 0) begin
                    headCmd = cmdQ.pop_front();
                    sum += int'(headCmd.pulseLen);
                end
                if (sum < int'(cfg.minPulse)) begin
                    remModel = sum;
                    onModel = 0;
                end else begin
                    remModel = 0;
                    onModel = (sum > per) ? per : sum;
                end
                phase = 0;
                stepIdx++;
                sentThisStep = 1'b0;
            end else if (onModel == 0) begin
                phase = 0;
            end else begin
                phase = (phase + 1) % per;
            end
            expPwm = (phase < onModel);
            // write lands after the pop of the same edge
            if (cmdValid) begin
                cmdQ.push_back(cmd);
            end
            cycleIdx++;
            // host side for the coming cycle
            if (hostCredits > 0) begin
                if (stepIdx < SHORT_END || (stepIdx >= IDLE_END && stepIdx < SAT_END)) begin
                    // one command per step
                    if (!sentThisStep) begin
                        sendNow = (nextBits(1) == 1);
                    end
                    sel = (stepIdx < SHORT_END) ? 0 : 2;
                end else if (stepIdx >= SAT_END && stepIdx < BURST_END) begin
                    sendNow = (nextBits(1) == 1);
                    sel = nextBits(2);
                end
            end
            if (sendNow) begin
                cmdValid <= 1'b1;
                cmd.pulseLen <= pickPulse(sel);
                hostCredits--;
                sentThisStep = 1'b1;
            end else begin
                cmdValid <= 1'b0;
            end
        end
    end

    // outputs checked mid-cycle
    always @(negedge clk) begin
        logic expStep;
        int   seenCredits;
        int   expCredits;
        if (!arstN) begin
            retSeen = 1'b0;
            compareStepLast(stepLast, 1'b0);
            checkPwm(pwm, 1'b0);
        end else begin
            retSeen = creditReturn;
            expStep = (cycleIdx > 0) && (cycleIdx % int'(cfg.stepPeriod) == 0);
            compareStepLast(stepLast, expStep);
            checkPwm(pwm, expPwm);
            // credits the host holds once this cycle's return is counted
            seenCredits = hostCredits + int'(creditReturn);
            expCredits = FIFO_DEPTH - cmdQ.size() - int'(cmdValid);
            if (hostCredits < 0 || hostCredits > FIFO_DEPTH) begin
                otherErrs++;
                $display("host credit count outside 0 to FIFO_DEPTH at cycle %0d", cycleIdx);
            end
            expectCredits(FIFO_CNT_W'(seenCredits), FIFO_CNT_W'(expCredits));
            // last boundary of the run, fifo should be drained
            if (expStep && stepIdx == RUN_STEPS - 1) begin
                if (cmdQ.size() != 0 || u_motorPwmTop.notEmpty) begin
                    otherErrs++;
                    $display("commands still queued at the end of a run");
                end
                expectCredits(FIFO_CNT_W'(seenCredits), FIFO_CNT_W'(FIFO_DEPTH));
            end
        end
    end

    always @(posedge clk) begin
        timeoutCnt++;
        if (timeoutCnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        arstN = 1'b0;
        for (int run = 0; run < NUM_RUNS; run++) begin
            repeat (RESET_CYCLES) @(posedge clk);
            arstN <= 1'b1;
            wait (stepIdx == RUN_STEPS);
            @(posedge clk);
            arstN <= 1'b0;
        end
        @(negedge clk);
        $display("errors: pwm %0d stepLast %0d credits %0d other %0d",
                 pwmErrs, stepErrs, creditErrs, otherErrs);
        if (pwmErrs + stepErrs + creditErrs + otherErrs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== dv/motorPwm_sva.sv ====
`timescale 1ns/100ps

module motorPwm_sva
    import motorPwmPkg::*;
(
    input logic             clk,
    input logic             arstN,
    input motorCfgT         cfg,
    input logic             stepLast,
    input logic             notEmpty,
    input logic             creditReturn,
    input logic             pwm,
    input logic [PWM_W-1:0] onTime
);

    // cycles since the previous step boundary
    int stepGap;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            stepGap <= 0;
        end else begin
            stepGap <= stepLast ? 1 : stepGap + 1;
        end
    end

    // a credit only follows a real pop
    creditAfterPop: assert property (@(posedge clk) disable iff (!arstN)
        creditReturn |-> $past(stepLast && notEmpty))
        else $error("creditReturn without a pop in the cycle before");

    // nothing latched means nothing on the output
    pwmIdleLow: assert property (@(posedge clk) disable iff (!arstN)
        (onTime == '0) |-> !pwm)
        else $error("pwm high with zero on-time");

    // boundaries exactly stepPeriod apart
    stepSpacing: assert property (@(posedge clk) disable iff (!arstN)
        stepLast |-> (stepGap == int'(cfg.stepPeriod)))
        else $error("stepLast spacing differs from stepPeriod");

endmodule

// ==== motorPwmTop.f ====
verilog/motorPwmPkg.sv
verilog/stepCmdFifo.sv
verilog/stepTimer.sv
verilog/pwmGenerator.sv
verilog/motorPwmTop.sv
dv/motorPwm_sva.sv
dv/motorPwmTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the motor PWM testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f motorPwmTop.f --top-module motorPwmTb \
    > sim.log 2>&1 \
    && ./obj_dir/VmotorPwmTb >> sim.log 2>&1 \
    || echo "FAIL: see errors above" >> sim.log
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1 || exit 0

// ==== verilog/motorPwmPkg.sv ====
package motorPwmPkg;

    // width of a requested pulse length and of the carried remainder
    localparam int PULSE_W = 16;

    // width of the pwm period counter and of the minimum pulse
    // must not exceed PULSE_W, the capped on-time is cut from the sum
    localparam int PWM_W = 12;

    // width of the step period counter
    localparam int STEP_W = 16;

    // command entries, also the host's starting credit count
    // keep a power of two so the pointers wrap on their own
    localparam int FIFO_DEPTH = 8;

    // fifo pointer and occupancy widths
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    // remainder plus pulse length, one extra bit for the carry out
    localparam int SUM_W = PULSE_W + 1;

    // one step command from the host
    typedef struct packed {
        // on-time requested for one motor step, in clk cycles
        logic [PULSE_W-1:0] pulseLen;
    } stepCmdT;

    // static drive configuration
    typedef struct packed {
        // clk cycles per motor step
        logic [STEP_W-1:0] stepPeriod;
        // clk cycles per pwm period
        logic [PWM_W-1:0]  pwmPeriod;
        // shortest on-time the output stage is allowed to see
        logic [PWM_W-1:0]  minPulse;
    } motorCfgT;

endpackage

// ==== verilog/motorPwmTop.sv ====
`timescale 1ns/100ps

module motorPwmTop
    import motorPwmPkg::*;
(
    input  logic     clk,
    input  logic     arstN,
    input  motorCfgT cfg,
    input  logic     cmdValid,
    input  stepCmdT  cmd,
    output logic     pwm,
    output logic     stepLast,
    output logic     creditReturn
);

    stepCmdT            head;
    logic               notEmpty;
    logic               cmdPop;
    logic [PULSE_W-1:0] pulseSel;

    // one command per step boundary, if one is queued
    assign cmdPop = stepLast & notEmpty;
    // idle step runs with a zero request
    assign pulseSel = notEmpty ? head.pulseLen : '0;

    // host commands, credit based
    stepCmdFifo u_stepCmdFifo (
        .clk          (clk),
        .arstN        (arstN),
        .wrValid      (cmdValid),
        .wrData       (cmd),
        .pop          (cmdPop),
        .head         (head),
        .notEmpty     (notEmpty),
        .creditReturn (creditReturn)
    );

    // motor step cadence
    stepTimer u_stepTimer (
        .clk      (clk),
        .arstN    (arstN),
        .cfg      (cfg),
        .stepLast (stepLast)
    );

    // waveform
    pwmGenerator u_pwmGenerator (
        .clk      (clk),
        .arstN    (arstN),
        .cfg      (cfg),
        .stepLast (stepLast),
        .pulseLen (pulseSel),
        .pwm      (pwm)
    );

endmodule

// ==== verilog/pwmGenerator.sv ====
`timescale 1ns/100ps

module pwmGenerator
    import motorPwmPkg::*;
(
    input  logic               clk,
    input  logic               arstN,
    input  motorCfgT           cfg,
    input  logic               stepLast,
    input  logic [PULSE_W-1:0] pulseLen,
    output logic               pwm
);

    // pulse length still owed from earlier short steps
    logic [PULSE_W-1:0] remainder;
    // on-time for the running step
    logic [PWM_W-1:0]   onTime;
    // config seen at the last step boundary
    motorCfgT           cfgLat;
    // cycles left in the current pwm period
    logic [PWM_W-1:0]   pwmCnt;

    // minimum-pulse decision
    logic [SUM_W-1:0]   sum;
    logic               sumLess;
    logic               sumOver;
    logic [PWM_W-1:0]   sumCapped;

    // next-state view, pwm is registered from it
    logic [PWM_W-1:0]   onTimeNext;
    logic [PWM_W-1:0]   periodNext;
    logic [PWM_W-1:0]   pwmCntNext;
    logic [PWM_W-1:0]   elapsedNext;
    logic               cntReload;

    // carried remainder plus the new request
    assign sum = SUM_W'(remainder) + SUM_W'(pulseLen);
    // too short to emit, keep it for a later step
    assign sumLess = (sum < SUM_W'(cfg.minPulse));
    // longer than a pwm period, saturate
    assign sumOver = (sum > SUM_W'(cfg.pwmPeriod));
    assign sumCapped = sumOver ? cfg.pwmPeriod : sum[PWM_W-1:0];

    // remainder, on-time and config change only at a step boundary
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            remainder <= '0;
            onTime    <= '0;
            cfgLat    <= '0;
        end else if (stepLast) begin
            if (sumLess) begin
                // sum is below minPulse here, fits the remainder
                remainder <= sum[PULSE_W-1:0];
                onTime    <= '0;
            end else begin
                remainder <= '0;
                onTime    <= sumCapped;
            end
            cfgLat <= cfg;
        end
    end

    // period counter reloads
    // step boundary, end of period, or nothing to emit
    assign cntReload = stepLast || (pwmCnt == PWM_W'(1)) || (onTime == '0);

    always_comb begin
        if (stepLast) begin
            // values the boundary edge is about to load
            onTimeNext = sumLess ? '0 : sumCapped;
            periodNext = cfg.pwmPeriod;
        end else begin
            onTimeNext = onTime;
            periodNext = cfgLat.pwmPeriod;
        end
        if (cntReload) begin
            pwmCntNext = periodNext;
        end else begin
            pwmCntNext = pwmCnt - 1'b1;
        end
        // cycles already spent in the period after this edge
        elapsedNext = periodNext - pwmCntNext;
    end

    // counter and output register
    // pwm is high for the first onTime cycles of each period
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pwmCnt <= '0;
            pwm    <= 1'b0;
        end else begin
            pwmCnt <= pwmCntNext;
            pwm    <= (elapsedNext < onTimeNext);
        end
    end

    // capped on-time equal to the period keeps pwm high all step
    // a partial period at the step end is simply cut off

endmodule

// ==== verilog/stepCmdFifo.sv ====
`timescale 1ns/100ps

module stepCmdFifo
    import motorPwmPkg::*;
(
    input  logic    clk,
    input  logic    arstN,
    input  logic    wrValid,
    input  stepCmdT wrData,
    input  logic    pop,
    output stepCmdT head,
    output logic    notEmpty,
    output logic    creditReturn
);

    // entry storage, payload only
    stepCmdT mem [FIFO_DEPTH];

    logic [FIFO_PTR_W-1:0] rdPtr;
    logic [FIFO_PTR_W-1:0] wrPtr;
    logic [FIFO_CNT_W-1:0] count;

    logic notFull;
    logic wrAccept;
    logic popAccept;

    // occupancy flags
    assign notEmpty = (count != '0);
    assign notFull  = (count != FIFO_CNT_W'(FIFO_DEPTH));

    // host holds a credit for every write, full is only a safety net
    assign wrAccept  = wrValid & notFull;
    // pop on an empty fifo is dropped
    assign popAccept = pop & notEmpty;

    // show-ahead read, head is usable in the pop cycle
    assign head = mem[rdPtr];

    // storage write
    always_ff @(posedge clk) begin
        if (wrAccept) begin
            mem[wrPtr] <= wrData;
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            // pointers wrap at FIFO_DEPTH
            if (wrAccept) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (popAccept) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({wrAccept, popAccept})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                // both or neither, level unchanged
                default: count <= count;
            endcase
        end
    end

    // one credit back per popped entry
    // shows up the cycle after the pop
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            creditReturn <= 1'b0;
        end else begin
            creditReturn <= popAccept;
        end
    end

endmodule

// ==== verilog/stepTimer.sv ====
`timescale 1ns/100ps

module stepTimer
    import motorPwmPkg::*;
(
    input  logic     clk,
    input  logic     arstN,
    input  motorCfgT cfg,
    output logic     stepLast
);

    // cycles left in the current step, counts down to one
    logic [STEP_W-1:0] stepCnt;

    // zero only straight out of reset, before the first load
    logic cntIdle;

    assign cntIdle = (stepCnt == '0);

    // last cycle of the step
    // the counter reloads on the same edge
    assign stepLast = (stepCnt == STEP_W'(1));

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            stepCnt <= '0;
        end else begin
            if (stepLast || cntIdle) begin
                // new step of stepPeriod cycles
                stepCnt <= cfg.stepPeriod;
            end else begin
                stepCnt <= stepCnt - 1'b1;
            end
        end
    end

    // first load happens on the first edge after reset release,
    // so the first stepLast lands stepPeriod cycles later
    // a stepPeriod of one gives stepLast in every cycle

endmodule
